// ==== ics_periph_pkg.sv ====
//****************************************************************************
// Shared definitions for the peripheral block
// Bus and data widths, register byte offsets, AXI response codes
// Packed structs for the AXI4-Lite channels, register accesses and pins
//****************************************************************************

package ics_periph_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // Register byte offsets
    localparam logic [ADDR_W-1:0] REG_STATUS     = 8'h00;
    localparam logic [ADDR_W-1:0] REG_DSP_A      = 8'h04;
    localparam logic [ADDR_W-1:0] REG_DSP_B      = 8'h08;
    localparam logic [ADDR_W-1:0] REG_DSP_RESULT = 8'h0c;
    localparam logic [ADDR_W-1:0] REG_PAD        = 8'h10;
    localparam logic [ADDR_W-1:0] REG_FLASH      = 8'h14;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Master side of AXI4-Lite
    typedef struct packed {
        logic [ADDR_W-1:0]   awaddr;
        logic                awvalid;
        logic [DATA_W-1:0]   wdata;
        logic [DATA_W/8-1:0] wstrb;
        logic                wvalid;
        logic                bready;
        logic [ADDR_W-1:0]   araddr;
        logic                arvalid;
        logic                rready;
    } axil_req_t;

    // Slave side of AXI4-Lite
    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              bvalid;
        logic [1:0]        bresp;
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        logic [1:0]        rresp;
    } axil_rsp_t;

    // One register access, word addressed
    typedef struct packed {
        logic [ADDR_W-3:0]   index;
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
        logic                write;
        logic                valid;
    } reg_access_t;

    typedef struct packed {
        logic       clk;
        logic       csn;
        logic [3:0] io_out;
        logic [3:0] io_oe;
    } flash_pins_t;

    typedef struct packed {
        logic btn_u;
        logic btn_1;
        logic btn_2;
        logic btn_3;
    } pad_buttons_t;

endpackage

// ==== axil_periph_slave.sv ====
//****************************************************************************
// AXI4-Lite slave for the peripheral registers
// Turns aw/w and ar handshakes into single-cycle register accesses
// and holds the write and read responses until the master takes them
//****************************************************************************

`timescale 1ns/1ps

module axil_periph_slave (
    input  logic                              vdp_clk,
    input  logic                              vdp_reset,
    input  ics_periph_pkg::axil_req_t         axil_req,
    output ics_periph_pkg::axil_rsp_t         axil_rsp,
    output ics_periph_pkg::reg_access_t       access,
    input  logic [ics_periph_pkg::DATA_W-1:0] read_data,
    input  logic                              decode_error
);

    logic wr_accept;
    logic rd_accept;

    logic bvalid;
    logic [1:0] bresp;
    logic rvalid;
    logic [1:0] rresp;
    logic [ics_periph_pkg::DATA_W-1:0] rdata;

    // Address and data must arrive together, one write in flight
    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid;

    // Register port is shared, so a write in the same cycle goes first
    assign rd_accept = axil_req.arvalid && !rvalid && !wr_accept;

    always_comb begin
        access.valid = wr_accept || rd_accept;
        access.write = wr_accept;
        access.data = axil_req.wdata;
        access.strb = axil_req.wstrb;
        if (wr_accept) begin
            access.index = axil_req.awaddr[ics_periph_pkg::ADDR_W-1:2];
        end else begin
            access.index = axil_req.araddr[ics_periph_pkg::ADDR_W-1:2];
        end
    end

    // Write response channel
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            bvalid <= 1'b0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
        end else if (axil_req.bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (wr_accept) begin
            bresp <= decode_error ? ics_periph_pkg::RESP_SLVERR : ics_periph_pkg::RESP_OKAY;
        end
    end

    // Read data channel
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (rd_accept) begin
            rdata <= read_data;
            rresp <= decode_error ? ics_periph_pkg::RESP_SLVERR : ics_periph_pkg::RESP_OKAY;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_accept;
        axil_rsp.wready = wr_accept;
        axil_rsp.bvalid = bvalid;
        axil_rsp.bresp = bresp;
        axil_rsp.arready = rd_accept;
        axil_rsp.rvalid = rvalid;
        axil_rsp.rdata = rdata;
        axil_rsp.rresp = rresp;
    end

endmodule

// ==== periph_regs.sv ====
//****************************************************************************
// Peripheral register block
// Word decode, status LEDs, flash pin control, pad control, read mux
//****************************************************************************

`timescale 1ns/1ps

module periph_regs #(
    parameter int DSP_WIDTH = 16
) (
    input  logic                              vdp_clk,
    input  logic                              vdp_reset,
    input  ics_periph_pkg::reg_access_t       access,
    output logic [ics_periph_pkg::DATA_W-1:0] read_data,
    output logic                              decode_error,
    output logic                              dsp_a_we,
    output logic                              dsp_b_we,
    output logic [DSP_WIDTH-1:0]              dsp_data,
    input  logic [2*DSP_WIDTH-1:0]            product,
    output logic [1:0]                        pad_ctrl,
    input  logic [1:0]                        pad_bits,
    input  logic [3:0]                        flash_out,
    output logic [7:0]                        led,
    output ics_periph_pkg::flash_pins_t       flash
);

    localparam int IDX_W = ics_periph_pkg::ADDR_W - 2;
    localparam int DATA_W = ics_periph_pkg::DATA_W;

    // Word indices of the mapped registers
    localparam logic [IDX_W-1:0] IDX_STATUS = IDX_W'(ics_periph_pkg::REG_STATUS >> 2);
    localparam logic [IDX_W-1:0] IDX_DSP_A = IDX_W'(ics_periph_pkg::REG_DSP_A >> 2);
    localparam logic [IDX_W-1:0] IDX_DSP_B = IDX_W'(ics_periph_pkg::REG_DSP_B >> 2);
    localparam logic [IDX_W-1:0] IDX_RESULT = IDX_W'(ics_periph_pkg::REG_DSP_RESULT >> 2);
    localparam logic [IDX_W-1:0] IDX_PAD = IDX_W'(ics_periph_pkg::REG_PAD >> 2);
    localparam logic [IDX_W-1:0] IDX_FLASH = IDX_W'(ics_periph_pkg::REG_FLASH >> 2);

    logic wr_en;
    logic low_half;

    logic [7:0] status;

    logic flash_active;
    logic [3:0] flash_io_out;
    logic [3:0] flash_io_oe;
    logic flash_clk;
    logic flash_csn;

    assign wr_en = access.valid && access.write && !decode_error;
    assign low_half = |access.strb[1:0];

    assign dsp_data = access.data[DSP_WIDTH-1:0];
    assign dsp_a_we = wr_en && low_half && (access.index == IDX_DSP_A);
    assign dsp_b_we = wr_en && low_half && (access.index == IDX_DSP_B);

    // Status LEDs
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= 8'h00;
        end else if (wr_en && access.strb[0] && access.index == IDX_STATUS) begin
            status <= access.data[7:0];
        end
    end

    assign led = status;

    // Pad latch and clock, driven by software
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_ctrl <= 2'b00;
        end else if (wr_en && access.strb[0] && access.index == IDX_PAD) begin
            pad_ctrl <= access.data[1:0];
        end
    end

    // Bit-banged flash control
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            flash_active <= 1'b0;
            flash_io_oe <= 4'h0;
            flash_clk <= 1'b0;
            flash_csn <= 1'b1;
        end else if (wr_en && low_half && access.index == IDX_FLASH) begin
            flash_active <= access.data[15];
            flash_io_oe <= access.data[7:4];
            flash_clk <= access.data[8];
            flash_csn <= access.data[9];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (wr_en && low_half && access.index == IDX_FLASH) begin
            flash_io_out <= access.data[3:0];
        end
    end

    // Idle pins while software control is off
    always_comb begin
        if (flash_active) begin
            flash.clk = flash_clk;
            flash.csn = flash_csn;
            flash.io_out = flash_io_out;
            flash.io_oe = flash_io_oe;
        end else begin
            flash.clk = 1'b0;
            flash.csn = 1'b1;
            flash.io_out = 4'h0;
            flash.io_oe = 4'h0;
        end
    end

    // Read mux and decode
    always_comb begin
        read_data = '0;
        decode_error = 1'b0;
        case (access.index)
            IDX_STATUS: read_data = DATA_W'(status);
            IDX_DSP_A,
            IDX_DSP_B: read_data = '0;
            IDX_RESULT: read_data = DATA_W'(product);
            IDX_PAD: read_data = DATA_W'(pad_bits);
            IDX_FLASH: read_data = DATA_W'(flash_out);
            default: decode_error = 1'b1;
        endcase
    end

endmodule

// ==== dsp_multiplier.sv ====
//****************************************************************************
// Signed multiplier with operand registers and a registered product
//****************************************************************************

`timescale 1ns/1ps

module dsp_multiplier #(
    parameter int DSP_WIDTH = 16
) (
    input  logic                   vdp_clk,
    input  logic                   dsp_a_we,
    input  logic                   dsp_b_we,
    input  logic [DSP_WIDTH-1:0]   dsp_data,
    output logic [2*DSP_WIDTH-1:0] product
);

    logic signed [DSP_WIDTH-1:0] mult_a;
    logic signed [DSP_WIDTH-1:0] mult_b;

    // Operand registers loaded from the register block
    always_ff @(posedge vdp_clk) begin
        if (dsp_a_we) begin
            mult_a <= dsp_data;
        end
        if (dsp_b_we) begin
            mult_b <= dsp_data;
        end
    end

    // Product follows the operands one cycle later
    always_ff @(posedge vdp_clk) begin
        product <= mult_a * mult_b;
    end

endmodule

// ==== pad_shifter.sv ====
//****************************************************************************
// Gamepad stand-in built from the board buttons
// Latch and shift register clocked by software, synced user button
//****************************************************************************

`timescale 1ns/1ps

module pad_shifter #(
    parameter int PAD_BITS = 16
) (
    input  logic                         vdp_clk,
    input  logic                         vdp_reset,
    input  logic [1:0]                   pad_ctrl,
    input  ics_periph_pkg::pad_buttons_t buttons,
    output logic [1:0]                   pad_bits
);

    logic pad_latch;
    logic pad_clk;
    logic pad_clk_r;
    logic pad_clk_rise;

    logic [PAD_BITS-1:0] pad_state;
    logic [PAD_BITS-1:0] latch_value;
    logic user_button_r;

    assign pad_latch = pad_ctrl[0];
    assign pad_clk = pad_ctrl[1];
    assign pad_clk_rise = pad_clk && !pad_clk_r;

    // Left, right and B sit where a real pad reports them
    always_comb begin
        latch_value = '0;
        latch_value[7] = buttons.btn_1;
        latch_value[6] = buttons.btn_3;
        latch_value[0] = buttons.btn_2;
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_clk_r <= 1'b0;
        end else begin
            pad_clk_r <= pad_clk;
        end
    end

    // Shift takes priority over a held latch
    always_ff @(posedge vdp_clk) begin
        if (pad_clk_rise) begin
            pad_state <= {1'b0, pad_state[PAD_BITS-1:1]};
        end else if (pad_latch) begin
            pad_state <= latch_value;
        end
    end

    // User button sampled once per clock
    always_ff @(posedge vdp_clk) begin
        user_button_r <= buttons.btn_u;
    end

    // User button in place of second pad data
    assign pad_bits = {user_button_r, pad_state[0]};

endmodule

// ==== ics_periph_top.sv ====
//****************************************************************************
// Peripheral block top level
// AXI4-Lite slave, register block, DSP multiplier and gamepad shifter
//****************************************************************************

`timescale 1ns/1ps

module ics_periph_top #(
    parameter int DSP_WIDTH = 16,
    parameter int PAD_BITS = 16
) (
    input  logic                         vdp_clk,
    input  logic                         vdp_reset,
    input  ics_periph_pkg::axil_req_t    axil_req,
    output ics_periph_pkg::axil_rsp_t    axil_rsp,
    input  ics_periph_pkg::pad_buttons_t buttons,
    input  logic [3:0]                   flash_out,
    output logic [7:0]                   led,
    output ics_periph_pkg::flash_pins_t  flash
);

    ics_periph_pkg::reg_access_t access;

    logic [ics_periph_pkg::DATA_W-1:0] read_data;
    logic decode_error;

    logic dsp_a_we;
    logic dsp_b_we;
    logic [DSP_WIDTH-1:0] dsp_data;
    logic [2*DSP_WIDTH-1:0] product;

    logic [1:0] pad_ctrl;
    logic [1:0] pad_bits;

    axil_periph_slave u_slave (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .access       (access),
        .read_data    (read_data),
        .decode_error (decode_error)
    );

    periph_regs #(
        .DSP_WIDTH (DSP_WIDTH)
    ) u_regs (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .access       (access),
        .read_data    (read_data),
        .decode_error (decode_error),
        .dsp_a_we     (dsp_a_we),
        .dsp_b_we     (dsp_b_we),
        .dsp_data     (dsp_data),
        .product      (product),
        .pad_ctrl     (pad_ctrl),
        .pad_bits     (pad_bits),
        .flash_out    (flash_out),
        .led          (led),
        .flash        (flash)
    );

    dsp_multiplier #(
        .DSP_WIDTH (DSP_WIDTH)
    ) u_dsp (
        .vdp_clk  (vdp_clk),
        .dsp_a_we (dsp_a_we),
        .dsp_b_we (dsp_b_we),
        .dsp_data (dsp_data),
        .product  (product)
    );

    pad_shifter #(
        .PAD_BITS (PAD_BITS)
    ) u_pad (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .pad_ctrl  (pad_ctrl),
        .buttons   (buttons),
        .pad_bits  (pad_bits)
    );

endmodule

// ==== ics_periph_sva.sv ====
//****************************************************************************
// Concurrent assertions on the AXI4-Lite handshake of the peripheral slave
//****************************************************************************

`timescale 1ns/1ps

module ics_periph_sva (
    input logic                      vdp_clk,
    input logic                      vdp_reset,
    input ics_periph_pkg::axil_req_t axil_req,
    input ics_periph_pkg::axil_rsp_t axil_rsp
);

    // Responses stay up until the master takes them
    bvalid_held: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("Write response dropped before bready");

    rvalid_held: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else $error("Read response dropped or changed before rready");

    aw_with_w: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        axil_rsp.awready |-> axil_rsp.wready)
        else $error("Write address taken without write data");

    // One write in flight
    no_aw_pending: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        axil_rsp.awready |-> !axil_rsp.bvalid)
        else $error("Write accepted while a response was pending");

endmodule

// ==== ics_periph_checker.sv ====
//****************************************************************************
// Reference model of the peripheral registers, built from observed handshakes
// Compares read data, response codes, led and flash pins with the model
//****************************************************************************

`timescale 1ns/1ps

module ics_periph_checker (
    input  logic                         vdp_clk,
    input  logic                         vdp_reset,
    input  ics_periph_pkg::axil_req_t    axil_req,
    input  ics_periph_pkg::axil_rsp_t    axil_rsp,
    input  ics_periph_pkg::pad_buttons_t buttons,
    input  logic [3:0]                   flash_out,
    input  logic [7:0]                   led,
    input  ics_periph_pkg::flash_pins_t  flash,
    input  logic                         table_check,
    input  logic [31:0]                  table_expect,
    output int                           data_errors,
    output int                           resp_errors,
    output int                           out_errors
);

    logic armed = 1'b0;
    logic [7:0] m_status;
    logic [15:0] m_flash;
    logic signed [15:0] m_a;
    logic signed [15:0] m_b;
    logic [15:0] m_pad;
    logic m_pad_clk;
    logic [5:0] idx;
    logic [31:0] exp_rdata;
    logic [1:0] exp_rresp;
    logic [1:0] exp_bresp;
    ics_periph_pkg::flash_pins_t exp_pins;

    initial begin
        data_errors = 0;
        resp_errors = 0;
        out_errors = 0;
    end

    // Pad order: btn_1 at bit 7, btn_3 at bit 6, btn_2 at bit 0
    function automatic logic [15:0] pad_load(input ics_periph_pkg::pad_buttons_t b);
        logic [15:0] v;
        v = 16'h0000;
        v[7] = b.btn_1;
        v[6] = b.btn_3;
        v[0] = b.btn_2;
        return v;
    endfunction

    function automatic logic [1:0] resp_for(input logic [5:0] word);
        return (word <= 6'd5) ? ics_periph_pkg::RESP_OKAY : ics_periph_pkg::RESP_SLVERR;
    endfunction

    always @(posedge vdp_clk) begin
        if (vdp_reset) begin
            armed = 1'b0;
            m_status = 8'h00;
            m_flash = 16'h0000;
            m_pad_clk = 1'b0;
        end else begin
            armed = 1'b1;
            if (axil_rsp.bvalid && axil_req.bready && axil_rsp.bresp !== exp_bresp) begin
                resp_errors++;
                $display("Mismatch at %0t: bresp %0d, expected %0d", $time,
                         axil_rsp.bresp, exp_bresp);
            end
            if (axil_rsp.rvalid && axil_req.rready) begin
                if (axil_rsp.rdata !== exp_rdata ||
                        (table_check && axil_rsp.rdata !== table_expect)) begin
                    data_errors++;
                    $display("Mismatch at %0t: rdata 0x%08h, model 0x%08h, table 0x%08h",
                             $time, axil_rsp.rdata, exp_rdata, table_expect);
                end
                if (axil_rsp.rresp !== exp_rresp) begin
                    resp_errors++;
                    $display("Mismatch at %0t: rresp %0d, expected %0d", $time,
                             axil_rsp.rresp, exp_rresp);
                end
            end
            if (axil_rsp.awready) begin
                idx = axil_req.awaddr[7:2];
                exp_bresp = resp_for(idx);
                if (!axil_rsp.wready || axil_rsp.bvalid) begin
                    resp_errors++;
                    $display("Write taken without its data or over a pending response at %0t",
                             $time);
                end
                if (axil_req.wstrb[0]) begin
                    case (idx)
                        6'd0: m_status = axil_req.wdata[7:0];
                        6'd1: m_a = axil_req.wdata[15:0];
                        6'd2: m_b = axil_req.wdata[15:0];
                        6'd4: begin
                            if (axil_req.wdata[0]) begin
                                m_pad = pad_load(buttons);
                            end else if (axil_req.wdata[1] && !m_pad_clk) begin
                                m_pad = {1'b0, m_pad[15:1]};
                            end
                            m_pad_clk = axil_req.wdata[1];
                        end
                        6'd5: m_flash = axil_req.wdata[15:0];
                        default: ;
                    endcase
                end
            end
            if (axil_rsp.arready) begin
                idx = axil_req.araddr[7:2];
                exp_rresp = resp_for(idx);
                case (idx)
                    6'd0: exp_rdata = {24'h0, m_status};
                    6'd3: exp_rdata = 32'(m_a) * 32'(m_b);
                    6'd4: exp_rdata = {30'h0, buttons.btn_u, m_pad[0]};
                    6'd5: exp_rdata = {28'h0, flash_out};
                    default: exp_rdata = 32'h0;
                endcase
            end
        end
    end

    // Pins checked mid-cycle, away from the clock edge
    always @(negedge vdp_clk) begin
        if (armed) begin
            if (m_flash[15]) begin
                exp_pins.clk = m_flash[8];
                exp_pins.csn = m_flash[9];
                exp_pins.io_out = m_flash[3:0];
                exp_pins.io_oe = m_flash[7:4];
            end else begin
                exp_pins = '{clk: 1'b0, csn: 1'b1, io_out: 4'h0, io_oe: 4'h0};
            end
            if (led !== m_status || flash !== exp_pins) begin
                out_errors++;
                $display("Mismatch at %0t: led 0x%02h flash 0x%03h, expected 0x%02h 0x%03h",
                         $time, led, flash, m_status, exp_pins);
            end
        end
    end

endmodule

// ==== ics_periph_tb.sv ====
//****************************************************************************
// Testbench for the peripheral block
// Clock and reset, LFSR operands, stimulus table, AXI driver, watchdog
//****************************************************************************

`timescale 1ns/1ps

module ics_periph_tb;

    localparam int PERIOD = 100;
    localparam int ROW_CYCLES = 20;
    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ = 2'd1;
    localparam logic [1:0] OP_HOLD = 2'd2;

    typedef struct packed {
        logic [1:0]                   op;
        logic [7:0]                   addr;
        logic [31:0]                  data;
        ics_periph_pkg::pad_buttons_t btn;
        logic                         rnd;
        logic                         chk;
        logic [31:0]                  exp_data;
    } row_t;

    logic vdp_clk;
    logic vdp_reset;
    ics_periph_pkg::axil_req_t axil_req;
    ics_periph_pkg::axil_rsp_t axil_rsp;
    ics_periph_pkg::pad_buttons_t buttons;
    logic [3:0] flash_out;
    logic [7:0] led;
    ics_periph_pkg::flash_pins_t flash;
    logic table_check;
    logic [31:0] table_expect;
    int data_errors;
    int resp_errors;
    int out_errors;

    row_t rows[$];
    ics_periph_pkg::pad_buttons_t build_btn = 4'h0;
    logic [23:0] lfsr = 24'd81948;
    bit table_ready = 1'b0;

    ics_periph_top #(
        .DSP_WIDTH (16),
        .PAD_BITS  (16)
    ) DUT (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .buttons   (buttons),
        .flash_out (flash_out),
        .led       (led),
        .flash     (flash)
    );

    ics_periph_checker u_checker (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .buttons      (buttons),
        .flash_out    (flash_out),
        .led          (led),
        .flash        (flash),
        .table_check  (table_check),
        .table_expect (table_expect),
        .data_errors  (data_errors),
        .resp_errors  (resp_errors),
        .out_errors   (out_errors)
    );

    bind axil_periph_slave ics_periph_sva u_sva (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp)
    );

    initial begin
        vdp_clk = 1'b0;
        forever #(PERIOD / 2) vdp_clk = ~vdp_clk;
    end

    // x^24 + x^23 + x^22 + x^17 + 1
    function automatic logic [23:0] lfsr_next(input logic [23:0] s);
        return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
    endfunction

    task automatic take_random(input int n, output logic [31:0] value);
        value = 32'h0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // Bit seen on pad data after k shifts
    function automatic logic pad_bit(input ics_periph_pkg::pad_buttons_t b, input int k);
        case (k)
            0: return b.btn_2;
            6: return b.btn_3;
            7: return b.btn_1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic void add_row(input logic [1:0] op, input logic [7:0] addr,
                                    input logic [31:0] data, input logic rnd,
                                    input logic chk, input logic [31:0] exp_data);
        rows.push_back({op, addr, data, build_btn, rnd, chk, exp_data});
    endfunction

    task automatic build_table();
        ics_periph_pkg::pad_buttons_t pattern[2];
        pattern[0] = 4'b0110;
        pattern[1] = 4'b1001;
        add_row(OP_READ, ics_periph_pkg::REG_STATUS, 32'h0, 1'b0, 1'b1, 32'h0);
        add_row(OP_WRITE, ics_periph_pkg::REG_STATUS, 32'h5a, 1'b0, 1'b0, 32'h0);
        add_row(OP_READ, ics_periph_pkg::REG_STATUS, 32'h0, 1'b0, 1'b1, 32'h5a);
        for (int i = 0; i < 6; i++) begin
            add_row(OP_WRITE, ics_periph_pkg::REG_DSP_A, 32'h0, 1'b1, 1'b0, 32'h0);
            add_row(OP_WRITE, ics_periph_pkg::REG_DSP_B, 32'h0, 1'b1, 1'b0, 32'h0);
            add_row(OP_READ, ics_periph_pkg::REG_DSP_RESULT, 32'h0, 1'b0, 1'b0, 32'h0);
        end
        add_row(OP_READ, ics_periph_pkg::REG_DSP_A, 32'h0, 1'b0, 1'b1, 32'h0);
        // Active, csn low, clk high, oe 0xa, out 0x5
        add_row(OP_WRITE, ics_periph_pkg::REG_FLASH, 32'h81a5, 1'b0, 1'b0, 32'h0);
        add_row(OP_READ, ics_periph_pkg::REG_FLASH, 32'h0, 1'b0, 1'b1, 32'hc);
        add_row(OP_WRITE, ics_periph_pkg::REG_FLASH, 32'h02ff, 1'b0, 1'b0, 32'h0);
        for (int p = 0; p < 2; p++) begin
            build_btn = pattern[p];
            add_row(OP_WRITE, ics_periph_pkg::REG_PAD, 32'h1, 1'b0, 1'b0, 32'h0);
            add_row(OP_WRITE, ics_periph_pkg::REG_PAD, 32'h0, 1'b0, 1'b0, 32'h0);
            add_row(OP_READ, ics_periph_pkg::REG_PAD, 32'h0, 1'b0, 1'b1,
                    {30'h0, build_btn.btn_u, pad_bit(build_btn, 0)});
            for (int k = 1; k < 16; k++) begin
                add_row(OP_WRITE, ics_periph_pkg::REG_PAD, 32'h2, 1'b0, 1'b0, 32'h0);
                add_row(OP_WRITE, ics_periph_pkg::REG_PAD, 32'h0, 1'b0, 1'b0, 32'h0);
                add_row(OP_READ, ics_periph_pkg::REG_PAD, 32'h0, 1'b0, 1'b1,
                        {30'h0, build_btn.btn_u, pad_bit(build_btn, k)});
            end
        end
        build_btn = 4'h0;
        add_row(OP_WRITE, 8'h1c, 32'hff, 1'b0, 1'b0, 32'h0);
        add_row(OP_READ, 8'h1c, 32'h0, 1'b0, 1'b1, 32'h0);
        add_row(OP_READ, ics_periph_pkg::REG_STATUS, 32'h0, 1'b0, 1'b1, 32'h5a);
        add_row(OP_HOLD, ics_periph_pkg::REG_STATUS, 32'h3c, 1'b0, 1'b0, 32'h0);
        add_row(OP_READ, ics_periph_pkg::REG_STATUS, 32'h0, 1'b0, 1'b1, 32'h3c);
    endtask

    task automatic write_access(input logic [7:0] addr, input logic [31:0] data);
        axil_req.awaddr = addr;
        axil_req.wdata = data;
        axil_req.wstrb = 4'hf;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid = 1'b1;
        @(negedge vdp_clk);
        while (!axil_rsp.bvalid) @(negedge vdp_clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid = 1'b0;
    endtask

    task automatic read_access(input logic [7:0] addr);
        axil_req.araddr = addr;
        axil_req.arvalid = 1'b1;
        @(negedge vdp_clk);
        while (!axil_rsp.rvalid) @(negedge vdp_clk);
        axil_req.arvalid = 1'b0;
    endtask

    // Second write waits while bready and rready hold both responses
    task automatic hold_response(input logic [7:0] addr, input logic [31:0] data);
        axil_req.bready = 1'b0;
        axil_req.rready = 1'b0;
        write_access(addr, data);
        axil_req.awvalid = 1'b1;
        axil_req.wvalid = 1'b1;
        read_access(addr);
        repeat (4) @(negedge vdp_clk);
        axil_req.rready = 1'b1;
        axil_req.bready = 1'b1;
        @(negedge vdp_clk);
        while (!axil_rsp.bvalid) @(negedge vdp_clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid = 1'b0;
    endtask

    initial begin
        row_t row;
        int total;
        vdp_reset = 1'b1;
        axil_req = '0;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        buttons = 4'h0;
        flash_out = 4'hc;
        table_check = 1'b0;
        table_expect = 32'h0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge vdp_clk);
        @(negedge vdp_clk);
        vdp_reset = 1'b0;
        foreach (rows[i]) begin
            row = rows[i];
            @(negedge vdp_clk);
            buttons = row.btn;
            table_check = row.chk;
            table_expect = row.exp_data;
            if (row.rnd) begin
                take_random(16, row.data);
            end
            case (row.op)
                OP_WRITE: write_access(row.addr, row.data);
                OP_READ: read_access(row.addr);
                default: hold_response(row.addr, row.data);
            endcase
        end
        repeat (2) @(negedge vdp_clk);
        total = data_errors + resp_errors + out_errors;
        $display("Errors: read data %0d, response %0d, outputs %0d",
                 data_errors, resp_errors, out_errors);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat ((rows.size() + 2) * ROW_CYCLES) @(posedge vdp_clk);
        $display("Timeout: the stimulus table did not finish in time");
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== ics_periph.f ====
ics_periph_pkg.sv
axil_periph_slave.sv
periph_regs.sv
dsp_multiplier.sv
pad_shifter.sv
ics_periph_top.sv
ics_periph_sva.sv
ics_periph_checker.sv
ics_periph_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= ics_periph_tb
FILELIST ?= ics_periph.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_TEXT ?= Checks failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
